// ==== sources.f ====
hw/oq_geom_pkg.sv
hw/oq_regmap_pkg.sv
hw/oq_host_decode.sv
hw/oq_reg_file.sv
hw/oq_eval_flags.sv
hw/oq_regs.sv
tests/oq_regs_checker.sv
tests/oq_regs_tb.sv

// ==== tests/oq_regs_tb.sv ====
// Events and host accesses never overlap; random traffic comes from a fixed xorshift seed
module oq_regs_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import oq_geom_pkg::*;
   import oq_regmap_pkg::*;

   localparam int NUM_OPS     = 400;
   localparam int PLANNED_OPS = NUM_OPS + 4 * 64 + 40;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        pkt_stored;
   logic        pkt_dropped;
   queue_idx_t  dst_oq;
   word_cnt_t   stored_words;
   logic        pkt_removed;
   queue_idx_t  removed_oq;
   word_cnt_t   removed_words;
   logic        reg_req;
   logic        reg_rd_wr_l;
   reg_addr_t   reg_addr;
   reg_data_t   reg_wr_data;
   logic        reg_ack;
   reg_data_t   reg_rd_data;
   queue_mask_t oq_empty;
   queue_mask_t oq_full;

   logic        chk_rd;
   reg_data_t   exp_rd_data;
   logic        chk_flags;
   queue_mask_t exp_empty;
   queue_mask_t exp_full;
   int          err_cnt;
   int          chk_cnt;

   // Model state per queue
   int m_pkts [NUM_QUEUES];
   int m_words [NUM_QUEUES];
   int m_max [NUM_QUEUES];
   int m_thresh [NUM_QUEUES];
   int m_stored [NUM_QUEUES];
   int m_removed [NUM_QUEUES];
   int m_dropped [NUM_QUEUES];

   int unsigned rng = 40611;

   always #20 clk = ~clk;

   oq_regs i_oq_regs (.*);

   oq_regs_checker i_checker (.*);

   function automatic int unsigned next_random();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   function automatic reg_addr_t reg_address(input int q, input oq_reg_e r);
      return {2'b00, q[2:0], r};
   endfunction

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   function automatic reg_data_t ref_read(input reg_addr_t addr);
      int q;
      q = addr[5:3];
      if (addr[7:6] != 2'b00)
         return UNMAPPED_VALUE;
      case (oq_reg_e'(addr[2:0]))
         REG_NUM_PKTS_IN_Q:    return reg_data_t'(m_pkts[q]);
         REG_NUM_WORDS_LEFT:   return reg_data_t'(m_words[q]);
         REG_MAX_PKTS_IN_Q:    return reg_data_t'(m_max[q]);
         REG_FULL_THRESH:      return reg_data_t'(m_thresh[q]);
         REG_NUM_PKTS_STORED:  return reg_data_t'(m_stored[q]);
         REG_NUM_PKTS_REMOVED: return reg_data_t'(m_removed[q]);
         REG_NUM_PKTS_DROPPED: return reg_data_t'(m_dropped[q]);
         default:              return '0;
      endcase
   endfunction

   function automatic void ref_flags(output queue_mask_t empty, output queue_mask_t full);
      for (int q = 0; q < NUM_QUEUES; q++) begin
         empty[q] = (m_pkts[q] == 0);
         full[q]  = (m_pkts[q] >= m_max[q]) || (m_words[q] < m_thresh[q]);
      end
   endfunction

   task automatic clear_queue(input int q);
      m_pkts[q]    = 0;
      m_words[q]   = QUEUE_WORDS;
      m_stored[q]  = 0;
      m_removed[q] = 0;
      m_dropped[q] = 0;
   endtask

   task automatic model_write(input reg_addr_t addr, input reg_data_t data);
      int q;
      q = addr[5:3];
      if (addr[7:6] == 2'b00) begin
         case (oq_reg_e'(addr[2:0]))
            REG_CTRL:          clear_queue(q);
            REG_MAX_PKTS_IN_Q: m_max[q] = data[15:0];
            REG_FULL_THRESH:   m_thresh[q] = data[12:0];
            default:           ;
         endcase
      end
   endtask

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   task automatic host_access(input logic wr, input reg_addr_t addr, input reg_data_t data);
      @(negedge clk);
      reg_req     = 1'b1;
      reg_rd_wr_l = ~wr;
      reg_addr    = addr;
      reg_wr_data = data;
      chk_rd      = ~wr;
      exp_rd_data = ref_read(addr);
      @(negedge clk);
      reg_req = 1'b0;
      while (reg_ack !== 1'b1) @(negedge clk);
      @(negedge clk);
      chk_rd = 1'b0;
      if (wr)
         model_write(addr, data);
   endtask

   task automatic check_flags();
      repeat (3) @(negedge clk);
      ref_flags(exp_empty, exp_full);
      chk_flags = 1'b1;
      @(negedge clk);
      chk_flags = 1'b0;
   endtask

   task automatic read_all();
      for (int q = 0; q < NUM_QUEUES; q++) begin
         for (int r = 0; r < 8; r++)
            host_access(1'b0, reg_address(q, oq_reg_e'(r)), '0);
      end
      check_flags();
   endtask

   task automatic event_cycle();
      logic [31:0] r;
      int          qs;
      int          qr;
      int          ws;
      int          wr_words;
      logic        st;
      logic        dr;
      logic        rm;
      r  = next_random();
      qs = r[2:0];
      qr = r[5:3];
      ws = int'(r[13:6]) + 1;
      st = (r[16:14] < 3'd5);
      dr = (r[16:14] == 3'd5) || (r[16:14] == 3'd6);
      rm = r[17] && (m_pkts[qr] > 0);
      // No room left turns the store into a drop
      if (st && m_words[qs] < ws) begin
         st = 1'b0;
         dr = 1'b1;
      end
      // Each packet still in the queue holds at least one word
      if (m_pkts[qr] == 1)
         wr_words = QUEUE_WORDS - m_words[qr];
      else
         wr_words = 1 + int'(next_random() % (QUEUE_WORDS - m_words[qr] - m_pkts[qr] + 1));
      @(negedge clk);
      pkt_stored    = st;
      pkt_dropped   = dr;
      dst_oq        = queue_idx_t'(qs);
      stored_words  = word_cnt_t'(ws);
      pkt_removed   = rm;
      removed_oq    = queue_idx_t'(qr);
      removed_words = word_cnt_t'(wr_words);
      if (st) begin
         m_pkts[qs]++;
         m_words[qs] -= ws;
         m_stored[qs]++;
      end
      if (dr)
         m_dropped[qs]++;
      if (rm) begin
         m_pkts[qr]--;
         m_words[qr] += wr_words;
         m_removed[qr]++;
      end
      @(negedge clk);
      pkt_stored  = 1'b0;
      pkt_dropped = 1'b0;
      pkt_removed = 1'b0;
   endtask

   task automatic store_packet(input int q, input int words);
      @(negedge clk);
      pkt_stored   = 1'b1;
      dst_oq       = queue_idx_t'(q);
      stored_words = word_cnt_t'(words);
      m_pkts[q]++;
      m_words[q] -= words;
      m_stored[q]++;
      @(negedge clk);
      pkt_stored = 1'b0;
   endtask

   initial begin
      int unsigned r;
      rst_n         = 1'b0;
      pkt_stored    = 1'b0;
      pkt_dropped   = 1'b0;
      dst_oq        = '0;
      stored_words  = '0;
      pkt_removed   = 1'b0;
      removed_oq    = '0;
      removed_words = '0;
      reg_req       = 1'b0;
      reg_rd_wr_l   = 1'b1;
      reg_addr      = '0;
      reg_wr_data   = '0;
      chk_rd        = 1'b0;
      exp_rd_data   = '0;
      chk_flags     = 1'b0;
      exp_empty     = '1;
      exp_full      = '0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         clear_queue(q);
         m_max[q]    = MAX_PKTS_RESET;
         m_thresh[q] = FULL_THRESH_RESET;
      end
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      read_all();

      // Random traffic with reads in between
      for (int i = 0; i < NUM_OPS; i++) begin
         r = next_random();
         if (r[31:30] == 2'b00) begin
            host_access(1'b0, reg_address(r[5:3], oq_reg_e'(r[2:0])), '0);
            check_flags();
         end else begin
            event_cycle();
         end
      end
      read_all();

      // Packet limit lowered, then word threshold raised
      host_access(1'b1, reg_address(1, REG_MAX_PKTS_IN_Q), reg_data_t'(m_pkts[1]));
      check_flags();
      host_access(1'b1, reg_address(2, REG_FULL_THRESH), reg_data_t'(m_words[2] + 1));
      check_flags();

      // Queue 3 runs short of words before its reinit
      while (m_words[3] >= m_thresh[3])
         store_packet(3, 200);
      check_flags();
      host_access(1'b1, reg_address(3, REG_CTRL), '0);
      read_all();

      // Read-only and spare-bit addresses
      host_access(1'b1, reg_address(4, REG_NUM_PKTS_IN_Q), 32'h0000_1234);
      host_access(1'b1, reg_address(5, REG_NUM_WORDS_LEFT), 32'h0000_0005);
      host_access(1'b1, {2'b10, 3'd0, REG_MAX_PKTS_IN_Q}, 32'h0000_0001);
      host_access(1'b1, {2'b01, 3'd2, REG_CTRL}, '0);
      host_access(1'b0, {2'b11, 6'h15}, '0);
      read_all();

      repeat (2) @(negedge clk);
      $display("checks %0d errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (PLANNED_OPS * 10 + 100) @(posedge clk);
      $display("Watchdog expired: reg_ack missing or the test hung, %0d errors so far", err_cnt);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== tests/oq_regs_checker.sv ====
// Compares at rising edges; expects reg_ack two cycles after each reg_req and stable tb inputs
module oq_regs_checker (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     reg_req,
   input  logic                     reg_ack,
   input  oq_regmap_pkg::reg_data_t reg_rd_data,
   input  oq_geom_pkg::queue_mask_t oq_empty,
   input  oq_geom_pkg::queue_mask_t oq_full,

   // Expected values from the testbench
   input  logic                     chk_rd,
   input  oq_regmap_pkg::reg_data_t exp_rd_data,
   input  logic                     chk_flags,
   input  oq_geom_pkg::queue_mask_t exp_empty,
   input  oq_geom_pkg::queue_mask_t exp_full,

   output int                       err_cnt,
   output int                       chk_cnt
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [1:0] req_d;

   task automatic log_mismatch(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      err_cnt++;
      $display("error %0t %s expected %h actual %h", $time, name, exp_v, act_v);
   endtask

   initial begin
      err_cnt = 0;
      chk_cnt = 0;
   end

   // Request history for the acknowledge timing
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         req_d <= 2'b00;
      else
         req_d <= {req_d[0], reg_req};
   end

   always @(posedge clk) begin
      if (rst_n) begin
         if (req_d[1] || reg_ack) begin
            chk_cnt++;
            if (reg_ack !== req_d[1])
               log_mismatch("reg_ack", 32'(req_d[1]), 32'(reg_ack));
         end
         if (reg_ack === 1'b1 && chk_rd) begin
            chk_cnt++;
            if (reg_rd_data !== exp_rd_data)
               log_mismatch("reg_rd_data", exp_rd_data, reg_rd_data);
         end
         if (chk_flags) begin
            chk_cnt++;
            if (oq_empty !== exp_empty)
               log_mismatch("oq_empty", 32'(exp_empty), 32'(oq_empty));
            if (oq_full !== exp_full)
               log_mismatch("oq_full", 32'(exp_full), 32'(oq_full));
         end
      end
   end

endmodule

// ==== hw/oq_regs.sv ====
// Output-queue bookkeeping top; reg_ack follows reg_req by two cycles, flags lag events by two
module oq_regs (
   input  logic                     clk,
   input  logic                     rst_n,

   // Store side
   input  logic                     pkt_stored,
   input  logic                     pkt_dropped,
   input  oq_geom_pkg::queue_idx_t  dst_oq,
   input  oq_geom_pkg::word_cnt_t   stored_words,

   // Remove side
   input  logic                     pkt_removed,
   input  oq_geom_pkg::queue_idx_t  removed_oq,
   input  oq_geom_pkg::word_cnt_t   removed_words,

   // Host
   input  logic                     reg_req,
   input  logic                     reg_rd_wr_l,
   input  oq_regmap_pkg::reg_addr_t reg_addr,
   input  oq_regmap_pkg::reg_data_t reg_wr_data,
   output logic                     reg_ack,
   output oq_regmap_pkg::reg_data_t reg_rd_data,

   output oq_geom_pkg::queue_mask_t oq_empty,
   output oq_geom_pkg::queue_mask_t oq_full
);

   import oq_geom_pkg::*;
   import oq_regmap_pkg::*;

   logic       acc_valid;
   logic       acc_wr;
   logic       acc_mapped;
   queue_idx_t acc_queue;
   oq_reg_e    acc_reg;
   reg_data_t  acc_wr_data;

   logic       upd_valid;
   queue_idx_t upd_queue;
   pkt_cnt_t   upd_pkts_in_q;
   pkt_cnt_t   upd_max_pkts;
   word_cnt_t  upd_words_left;
   word_cnt_t  upd_full_thresh;

   oq_host_decode i_host_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .acc_valid   (acc_valid),
      .acc_wr      (acc_wr),
      .acc_mapped  (acc_mapped),
      .acc_queue   (acc_queue),
      .acc_reg     (acc_reg),
      .acc_wr_data (acc_wr_data)
   );

   oq_reg_file i_reg_file (
      .clk             (clk),
      .rst_n           (rst_n),
      .acc_valid       (acc_valid),
      .acc_wr          (acc_wr),
      .acc_mapped      (acc_mapped),
      .acc_queue       (acc_queue),
      .acc_reg         (acc_reg),
      .acc_wr_data     (acc_wr_data),
      .pkt_stored      (pkt_stored),
      .pkt_dropped     (pkt_dropped),
      .dst_oq          (dst_oq),
      .stored_words    (stored_words),
      .pkt_removed     (pkt_removed),
      .removed_oq      (removed_oq),
      .removed_words   (removed_words),
      .reg_ack         (reg_ack),
      .reg_rd_data     (reg_rd_data),
      .upd_valid       (upd_valid),
      .upd_queue       (upd_queue),
      .upd_pkts_in_q   (upd_pkts_in_q),
      .upd_max_pkts    (upd_max_pkts),
      .upd_words_left  (upd_words_left),
      .upd_full_thresh (upd_full_thresh)
   );

   oq_eval_flags i_eval_flags (
      .clk             (clk),
      .rst_n           (rst_n),
      .upd_valid       (upd_valid),
      .upd_queue       (upd_queue),
      .upd_pkts_in_q   (upd_pkts_in_q),
      .upd_max_pkts    (upd_max_pkts),
      .upd_words_left  (upd_words_left),
      .upd_full_thresh (upd_full_thresh),
      .oq_empty        (oq_empty),
      .oq_full         (oq_full)
   );

endmodule

// ==== hw/oq_eval_flags.sv ====
// Full and empty flags; a queue's flags only move when its update arrives on upd_valid
module oq_eval_flags (
   input  logic                     clk,
   input  logic                     rst_n,

   // Fresh values of one changed queue
   input  logic                     upd_valid,
   input  oq_geom_pkg::queue_idx_t  upd_queue,
   input  oq_geom_pkg::pkt_cnt_t    upd_pkts_in_q,
   input  oq_geom_pkg::pkt_cnt_t    upd_max_pkts,
   input  oq_geom_pkg::word_cnt_t   upd_words_left,
   input  oq_geom_pkg::word_cnt_t   upd_full_thresh,

   output oq_geom_pkg::queue_mask_t oq_empty,
   output oq_geom_pkg::queue_mask_t oq_full
);

   logic is_empty;
   logic pkt_limit_hit;
   logic word_limit_hit;
   logic is_full;

   // ----------------------------------------------------------------------
   // Flag conditions for the queue being updated
   // ----------------------------------------------------------------------
   assign is_empty       = (upd_pkts_in_q == '0);
   assign pkt_limit_hit  = (upd_pkts_in_q >= upd_max_pkts);

   // Not enough room left for a largest packet
   assign word_limit_hit = (upd_words_left < upd_full_thresh);
   assign is_full        = pkt_limit_hit || word_limit_hit;

   // ----------------------------------------------------------------------
   // Flag registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         oq_empty <= '1;
         oq_full  <= '0;
      end else if (upd_valid) begin
         oq_empty[upd_queue] <= is_empty;
         oq_full[upd_queue]  <= is_full;
      end
   end

endmodule

// ==== hw/oq_reg_file.sv ====
// Per-queue registers; assumes no remove from an empty queue and no store with a drop
module oq_reg_file (
   input  logic                     clk,
   input  logic                     rst_n,

   // Decoded host access
   input  logic                     acc_valid,
   input  logic                     acc_wr,
   input  logic                     acc_mapped,
   input  oq_geom_pkg::queue_idx_t  acc_queue,
   input  oq_regmap_pkg::oq_reg_e   acc_reg,
   input  oq_regmap_pkg::reg_data_t acc_wr_data,

   // Store side
   input  logic                     pkt_stored,
   input  logic                     pkt_dropped,
   input  oq_geom_pkg::queue_idx_t  dst_oq,
   input  oq_geom_pkg::word_cnt_t   stored_words,

   // Remove side
   input  logic                     pkt_removed,
   input  oq_geom_pkg::queue_idx_t  removed_oq,
   input  oq_geom_pkg::word_cnt_t   removed_words,

   output logic                     reg_ack,
   output oq_regmap_pkg::reg_data_t reg_rd_data,

   // Fresh values of one changed queue
   output logic                     upd_valid,
   output oq_geom_pkg::queue_idx_t  upd_queue,
   output oq_geom_pkg::pkt_cnt_t    upd_pkts_in_q,
   output oq_geom_pkg::pkt_cnt_t    upd_max_pkts,
   output oq_geom_pkg::word_cnt_t   upd_words_left,
   output oq_geom_pkg::word_cnt_t   upd_full_thresh
);

   import oq_geom_pkg::*;
   import oq_regmap_pkg::*;

   pkt_cnt_t    pkts_in_q    [NUM_QUEUES];
   word_cnt_t   words_left   [NUM_QUEUES];
   pkt_cnt_t    max_pkts     [NUM_QUEUES];
   word_cnt_t   full_thresh  [NUM_QUEUES];
   pkt_cnt_t    pkts_stored  [NUM_QUEUES];
   pkt_cnt_t    pkts_removed [NUM_QUEUES];
   pkt_cnt_t    pkts_dropped [NUM_QUEUES];

   logic        host_wr;
   logic        host_chg;
   queue_mask_t store_mask;
   queue_mask_t remove_mask;
   queue_mask_t host_mask;
   queue_mask_t pend;
   queue_mask_t cand;
   queue_mask_t pick;
   queue_idx_t  sel;
   reg_data_t   rd_value;

   assign host_wr  = acc_valid && acc_wr && acc_mapped;
   assign host_chg = host_wr && (acc_reg inside {REG_CTRL, REG_MAX_PKTS_IN_Q, REG_FULL_THRESH});

   // Queues whose flags may move; drops leave them alone
   assign store_mask  = pkt_stored  ? (queue_mask_t'(1) << dst_oq)     : '0;
   assign remove_mask = pkt_removed ? (queue_mask_t'(1) << removed_oq) : '0;
   assign host_mask   = host_chg    ? (queue_mask_t'(1) << acc_queue)  : '0;

   // ----------------------------------------------------------------------
   // Register storage, one block per queue
   // ----------------------------------------------------------------------
   for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
      logic st_hit;
      logic rm_hit;
      logic dr_hit;
      logic wr_hit;

      assign st_hit = store_mask[q];
      assign rm_hit = remove_mask[q];
      assign dr_hit = pkt_dropped && (dst_oq == queue_idx_t'(q));
      assign wr_hit = host_wr && (acc_queue == queue_idx_t'(q));

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            pkts_in_q[q]    <= '0;
            words_left[q]   <= word_cnt_t'(QUEUE_WORDS);
            max_pkts[q]     <= MAX_PKTS_RESET;
            full_thresh[q]  <= FULL_THRESH_RESET;
            pkts_stored[q]  <= '0;
            pkts_removed[q] <= '0;
            pkts_dropped[q] <= '0;
         end else if (wr_hit && acc_reg == REG_CTRL) begin
            // Reinit beats any packet event in the same cycle
            pkts_in_q[q]    <= '0;
            words_left[q]   <= word_cnt_t'(QUEUE_WORDS);
            pkts_stored[q]  <= '0;
            pkts_removed[q] <= '0;
            pkts_dropped[q] <= '0;
         end else begin
            pkts_in_q[q]    <= pkts_in_q[q] + pkt_cnt_t'(st_hit) - pkt_cnt_t'(rm_hit);
            words_left[q]   <= words_left[q] - (st_hit ? stored_words : '0)
                               + (rm_hit ? removed_words : '0);
            pkts_stored[q]  <= pkts_stored[q] + pkt_cnt_t'(st_hit);
            pkts_removed[q] <= pkts_removed[q] + pkt_cnt_t'(rm_hit);
            pkts_dropped[q] <= pkts_dropped[q] + pkt_cnt_t'(dr_hit);
            if (wr_hit && acc_reg == REG_MAX_PKTS_IN_Q) begin
               max_pkts[q] <= pkt_cnt_t'(acc_wr_data);
            end
            if (wr_hit && acc_reg == REG_FULL_THRESH) begin
               full_thresh[q] <= word_cnt_t'(acc_wr_data);
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // Update sequencing, one queue per cycle
   // ----------------------------------------------------------------------
   assign cand = pend | store_mask | host_mask | remove_mask;

   // Backlog first, then store side, host, remove side
   always_comb begin
      if (pend != '0)
         pick = pend;
      else if (store_mask != '0)
         pick = store_mask;
      else if (host_mask != '0)
         pick = host_mask;
      else
         pick = remove_mask;
   end

   always_comb begin
      sel = '0;
      for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
         if (pick[i]) sel = queue_idx_t'(i);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend      <= '0;
         upd_valid <= 1'b0;
         upd_queue <= '0;
      end else begin
         pend      <= cand & ~(queue_mask_t'(1) << sel);
         upd_valid <= (cand != '0);
         upd_queue <= sel;
      end
   end

   assign upd_pkts_in_q   = pkts_in_q[upd_queue];
   assign upd_max_pkts    = max_pkts[upd_queue];
   assign upd_words_left  = words_left[upd_queue];
   assign upd_full_thresh = full_thresh[upd_queue];

   // ----------------------------------------------------------------------
   // Host read and acknowledge
   // ----------------------------------------------------------------------
   always_comb begin
      if (!acc_mapped) begin
         rd_value = UNMAPPED_VALUE;
      end else begin
         case (acc_reg)
            REG_NUM_PKTS_IN_Q:    rd_value = reg_data_t'(pkts_in_q[acc_queue]);
            REG_NUM_WORDS_LEFT:   rd_value = reg_data_t'(words_left[acc_queue]);
            REG_MAX_PKTS_IN_Q:    rd_value = reg_data_t'(max_pkts[acc_queue]);
            REG_FULL_THRESH:      rd_value = reg_data_t'(full_thresh[acc_queue]);
            REG_NUM_PKTS_STORED:  rd_value = reg_data_t'(pkts_stored[acc_queue]);
            REG_NUM_PKTS_REMOVED: rd_value = reg_data_t'(pkts_removed[acc_queue]);
            REG_NUM_PKTS_DROPPED: rd_value = reg_data_t'(pkts_dropped[acc_queue]);
            default:              rd_value = '0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= acc_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (acc_valid) begin
         reg_rd_data <= rd_value;
      end
   end

endmodule

// ==== hw/oq_host_decode.sv ====
// Host request stage; expects single-cycle reg_req pulses and no new request before reg_ack
module oq_host_decode (
   input  logic                     clk,
   input  logic                     rst_n,

   // Host request
   input  logic                     reg_req,
   input  logic                     reg_rd_wr_l,
   input  oq_regmap_pkg::reg_addr_t reg_addr,
   input  oq_regmap_pkg::reg_data_t reg_wr_data,

   // Decoded access towards the register file
   output logic                     acc_valid,
   output logic                     acc_wr,
   output logic                     acc_mapped,
   output oq_geom_pkg::queue_idx_t  acc_queue,
   output oq_regmap_pkg::oq_reg_e   acc_reg,
   output oq_regmap_pkg::reg_data_t acc_wr_data
);

   import oq_geom_pkg::*;
   import oq_regmap_pkg::*;

   logic addr_ok;

   // Upper address bits are spare
   assign addr_ok = (reg_addr[REG_ADDR_WIDTH-1:ADDR_SPARE_LSB] == '0);

   // ----------------------------------------------------------------------
   // Request qualifiers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_valid  <= 1'b0;
         acc_wr     <= 1'b0;
         acc_mapped <= 1'b0;
      end else begin
         acc_valid <= reg_req;
         if (reg_req) begin
            acc_wr     <= ~reg_rd_wr_l;
            acc_mapped <= addr_ok;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Address split and write data
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reg_req) begin
         acc_queue   <= reg_addr[ADDR_QUEUE_LSB +: QUEUE_IDX_WIDTH];
         acc_reg     <= oq_reg_e'(reg_addr[ADDR_REG_LSB +: $bits(oq_reg_e)]);
         acc_wr_data <= reg_wr_data;
      end
   end

endmodule

// ==== hw/oq_regmap_pkg.sv ====
// Host register map; address bits 7:6 must be zero, other addresses read as UNMAPPED_VALUE
package oq_regmap_pkg;

   localparam int REG_DATA_WIDTH = 32;
   localparam int REG_ADDR_WIDTH = 8;

   // Address fields: spare bits, queue number, register index
   localparam int ADDR_SPARE_LSB = 6;
   localparam int ADDR_QUEUE_LSB = 3;
   localparam int ADDR_REG_LSB   = 0;

   typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

   typedef enum logic [2:0] {
      REG_CTRL             = 3'd0,
      REG_NUM_PKTS_IN_Q    = 3'd1,
      REG_NUM_WORDS_LEFT   = 3'd2,
      REG_MAX_PKTS_IN_Q    = 3'd3,
      REG_FULL_THRESH      = 3'd4,
      REG_NUM_PKTS_STORED  = 3'd5,
      REG_NUM_PKTS_REMOVED = 3'd6,
      REG_NUM_PKTS_DROPPED = 3'd7
   } oq_reg_e;

   localparam reg_data_t UNMAPPED_VALUE = 32'hDEAD_BEEF;

endpackage

// ==== hw/oq_geom_pkg.sv ====
// Queue geometry for eight output queues of 4096 words each; widths assume 8-byte words
package oq_geom_pkg;

   // ----------------------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------------------
   localparam int NUM_QUEUES      = 8;
   localparam int QUEUE_IDX_WIDTH = $clog2(NUM_QUEUES);
   localparam int QUEUE_WORDS     = 4096;

   // One extra bit so a completely free queue still fits
   localparam int WORD_CNT_WIDTH  = $clog2(QUEUE_WORDS) + 1;
   localparam int PKT_CNT_WIDTH   = 16;

   // Largest packet and word size
   localparam int MAX_PKT_BYTES   = 2048;
   localparam int WORD_BYTES      = 8;

   typedef logic [QUEUE_IDX_WIDTH-1:0] queue_idx_t;
   typedef logic [WORD_CNT_WIDTH-1:0]  word_cnt_t;
   typedef logic [PKT_CNT_WIDTH-1:0]   pkt_cnt_t;
   typedef logic [NUM_QUEUES-1:0]      queue_mask_t;

   // ----------------------------------------------------------------------
   // Reset values of the per-queue limits
   // ----------------------------------------------------------------------
   localparam pkt_cnt_t  MAX_PKTS_RESET    = pkt_cnt_t'(512);

   // Room for one more packet of the largest size
   localparam word_cnt_t FULL_THRESH_RESET = word_cnt_t'(MAX_PKT_BYTES / WORD_BYTES);

endpackage
